// ==== logic/ulpb_pkg.sv ====
`default_nettype none

package ulpb_pkg;

	localparam int START_CYCLES = 12;
	localparam int START_CNT_W = $clog2(START_CYCLES + 1);

	// Bus reset pattern, sent MSB first
	localparam logic [2:0] RST_SEQ = 3'b010;
	localparam logic [1:0] ACK_SEQ = 2'b10;
	localparam logic [1:0] MES_SEQ = 2'b10;

	// Bit 5 marks the quarter rate states
	typedef enum logic [5:0] {
		BUS_IDLE          = 6'b000000,
		WAIT_FOR_START    = 6'b000001,
		ENABLE_CLK_NEG    = 6'b000010,
		ARBI_RES_POS      = 6'b000011,
		ARBI_RES_NEG      = 6'b000100,
		DRIVE1_POS        = 6'b000101,
		DRIVE1_NEG        = 6'b000110,
		LATCH1_POS        = 6'b000111,
		LATCH1_NEG        = 6'b001000,
		DRIVE2_POS        = 6'b001001,
		DRIVE2_NEG        = 6'b001010,
		LATCH2_POS        = 6'b001011,
		LATCH2_NEG        = 6'b001100,
		RESET_S0_D_NEG    = 6'b101101,
		RESET_S0_D_POS    = 6'b101110,
		RESET_S0_L_NEG    = 6'b101111,
		RESET_S0_L_POS    = 6'b110000,
		RESET_S1_D_NEG    = 6'b110001,
		RESET_S1_D_POS    = 6'b110010,
		RESET_S1_L_NEG    = 6'b110011,
		RESET_S1_L_POS    = 6'b110100,
		RESET_S0_D1_NEG   = 6'b110101,
		RESET_S0_D1_POS   = 6'b110110,
		RESET_S0_L1_NEG   = 6'b110111,
		RESET_S0_L1_POS   = 6'b111000,
		RESET_R_ALIGN_NEG = 6'b111001,
		RESET_R_ALIGN_POS = 6'b111010,
		RESET1_NEG        = 6'b111011,
		RESET1_POS        = 6'b111100,
		RESET2_NEG        = 6'b111101,
		RESET2_POS        = 6'b111110,
		RESET3_NEG        = 6'b111111,
		RESET3_POS        = 6'b100000,
		BACK_TO_IDLE_NEG  = 6'b100001,
		BACK_TO_IDLE_POS  = 6'b100010
	} med_state_e;

	typedef struct packed {
		logic       slow;
		logic [4:0] index;
	} med_state_s;

	typedef union packed {
		med_state_e code;
		med_state_s f;
	} med_state_u;

	typedef struct packed {
		logic       din_s;
		logic [3:0] hist;
	} sample_t;

	typedef struct packed {
		logic clk_level;
		logic hold;
		logic line_level;
		logic interject;
	} drive_t;

endpackage

`default_nettype wire

// ==== logic/bus_sampler.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_sampler (
	input  logic              CLK,
	input  logic              RESET,
	input  logic              din,
	input  logic              sample_strobe,
	output ulpb_pkg::sample_t sample
);

	logic din_meta;

	// Ring input is asynchronous to CLK
	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			din_meta <= 1'b1;
			sample.din_s <= 1'b1;
		end
		else
		begin
			din_meta <= din;
			sample.din_s <= din_meta;
		end
	end

	// Newest sample in bit 0
	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			sample.hist <= 4'hf;
		end
		else if (sample_strobe)
		begin
			sample.hist <= {sample.hist[2:0], sample.din_s};
		end
	end

endmodule

`default_nettype wire

// ==== logic/bus_mediator.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_mediator (
	input  logic                 CLK,
	input  logic                 RESET,
	input  ulpb_pkg::sample_t    sample,
	output logic                 sample_strobe,
	output ulpb_pkg::drive_t     drive,
	output ulpb_pkg::med_state_u state
);

	import ulpb_pkg::*;

	med_state_u             next_state;
	drive_t                 next_drive;
	logic                   half;
	logic                   next_half;
	logic [START_CNT_W-1:0] start_cnt;
	logic [START_CNT_W-1:0] next_cnt;
	logic [1:0]             seq_cnt;
	logic [1:0]             next_seq;
	logic [1:0]             rst_seen;
	logic [1:0]             next_rst_seen;
	logic                   phase_err;
	logic                   fault;

	// One history sample per quarter rate state, every cycle otherwise
	assign sample_strobe = ~(state.f.slow & half);
	assign phase_err = sample.hist[1] ^ sample.hist[0];

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			state.code <= BUS_IDLE;
			drive <= '{clk_level: 1'b1, hold: 1'b1, line_level: 1'b1, interject: 1'b0};
			half <= 1'b0;
			start_cnt <= START_CNT_W'(START_CYCLES);
			seq_cnt <= 2'd0;
			rst_seen <= 2'd0;
		end
		else
		begin
			state <= next_state;
			drive <= next_drive;
			half <= next_half;
			start_cnt <= next_cnt;
			seq_cnt <= next_seq;
			rst_seen <= next_rst_seen;
		end
	end

	always_comb
	begin
		next_state = state;
		next_drive = drive;
		next_drive.interject = 1'b0;
		next_half = half;
		next_cnt = start_cnt;
		next_seq = seq_cnt;
		next_rst_seen = rst_seen;
		fault = 1'b0;

		// Clock divider for the reset sequence
		if (state.f.slow)
			next_half = ~half;

		if (!state.f.slow || half)
		begin
			case (state.code)
				BUS_IDLE:
				begin
					if (!sample.din_s)
						next_state.code = WAIT_FOR_START;
					next_cnt = START_CNT_W'(START_CYCLES);
					next_seq = 2'd0;
					next_rst_seen = 2'd0;
				end
				WAIT_FOR_START:
				begin
					if (start_cnt != '0)
						next_cnt = start_cnt - 1'b1;
					else
					begin
						next_state.code = ENABLE_CLK_NEG;
						next_drive.clk_level = 1'b0;
					end
				end
				ENABLE_CLK_NEG:
				begin
					next_state.code = ARBI_RES_POS;
					next_drive.clk_level = 1'b1;
				end
				ARBI_RES_POS:
				begin
					next_state.code = ARBI_RES_NEG;
					next_drive.clk_level = 1'b0;
				end
				ARBI_RES_NEG:
				begin
					// Arbitration done, ring passes through
					next_state.code = DRIVE1_POS;
					next_drive.clk_level = 1'b1;
					next_drive.hold = 1'b0;
				end
				DRIVE1_POS:
				begin
					next_state.code = DRIVE1_NEG;
					next_drive.clk_level = 1'b0;
				end
				DRIVE1_NEG:
				begin
					if (phase_err)
						fault = 1'b1;
					else
					begin
						next_state.code = LATCH1_POS;
						next_drive.clk_level = 1'b1;
					end
				end
				LATCH1_POS:
				begin
					next_state.code = LATCH1_NEG;
					next_drive.clk_level = 1'b0;
				end
				LATCH1_NEG:
				begin
					if (seq_cnt != 2'd0 && sample.hist[0] != ACK_SEQ[1])
						fault = 1'b1;
					else
					begin
						if (seq_cnt != 2'd0)
							next_seq = seq_cnt + 1'b1;
						next_state.code = DRIVE2_POS;
						next_drive.clk_level = 1'b1;
					end
				end
				DRIVE2_POS:
				begin
					next_state.code = DRIVE2_NEG;
					next_drive.clk_level = 1'b0;
				end
				DRIVE2_NEG:
				begin
					if (phase_err)
						fault = 1'b1;
					else
					begin
						next_state.code = LATCH2_POS;
						next_drive.clk_level = 1'b1;
					end
				end
				LATCH2_POS:
				begin
					next_state.code = LATCH2_NEG;
					next_drive.clk_level = 1'b0;
				end
				LATCH2_NEG:
				begin
					next_state.code = DRIVE1_POS;
					next_drive.clk_level = 1'b1;
					if (seq_cnt == 2'd0)
					begin
						// A changing pair here is the end of message marker
						if (sample.hist[2] ^ sample.hist[0])
						begin
							if ({sample.hist[2], sample.hist[0]} == MES_SEQ)
								next_seq = seq_cnt + 1'b1;
							else
								fault = 1'b1;
						end
					end
					else
						// Message closes here whatever the second acknowledge bit
						fault = 1'b1;
				end
				RESET_S0_D_NEG:
				begin
					next_state.code = RESET_S0_D_POS;
					next_drive.clk_level = 1'b1;
				end
				RESET_S0_D_POS:
				begin
					next_state.code = RESET_S0_L_NEG;
					next_drive.clk_level = 1'b0;
				end
				RESET_S0_L_NEG:
				begin
					next_state.code = RESET_S0_L_POS;
					next_drive.clk_level = 1'b1;
				end
				RESET_S0_L_POS:
				begin
					if (sample.hist[2:0] == {3{RST_SEQ[2]}})
						next_rst_seen = {rst_seen[0], RST_SEQ[2]};
					next_state.code = RESET_S1_D_NEG;
					next_drive.line_level = RST_SEQ[1];
					next_drive.clk_level = 1'b0;
				end
				RESET_S1_D_NEG:
				begin
					next_state.code = RESET_S1_D_POS;
					next_drive.clk_level = 1'b1;
				end
				RESET_S1_D_POS:
				begin
					next_state.code = RESET_S1_L_NEG;
					next_drive.clk_level = 1'b0;
				end
				RESET_S1_L_NEG:
				begin
					next_state.code = RESET_S1_L_POS;
					next_drive.clk_level = 1'b1;
				end
				RESET_S1_L_POS:
				begin
					if (sample.hist == {4{RST_SEQ[1]}})
						next_rst_seen = {rst_seen[0], RST_SEQ[1]};
					next_state.code = RESET_S0_D1_NEG;
					next_drive.line_level = RST_SEQ[0];
					next_drive.clk_level = 1'b0;
				end
				RESET_S0_D1_NEG:
				begin
					next_state.code = RESET_S0_D1_POS;
					next_drive.clk_level = 1'b1;
				end
				RESET_S0_D1_POS:
				begin
					next_state.code = RESET_S0_L1_NEG;
					next_drive.clk_level = 1'b0;
				end
				RESET_S0_L1_NEG:
				begin
					next_state.code = RESET_S0_L1_POS;
					next_drive.clk_level = 1'b1;
				end
				RESET_S0_L1_POS:
				begin
					next_drive.clk_level = 1'b0;
					next_state.code = RESET_S1_D_NEG;
					next_drive.line_level = RST_SEQ[1];
					if (sample.hist == {4{RST_SEQ[0]}})
					begin
						next_rst_seen = {rst_seen[0], RST_SEQ[0]};
						// Whole pattern seen back on the ring
						if (rst_seen == RST_SEQ[2:1])
						begin
							next_state.code = RESET_R_ALIGN_NEG;
							next_drive.line_level = 1'b0;
						end
					end
				end
				RESET_R_ALIGN_NEG:
				begin
					next_state.code = RESET_R_ALIGN_POS;
					next_drive.clk_level = 1'b1;
				end
				RESET_R_ALIGN_POS:
				begin
					next_state.code = RESET1_NEG;
					next_drive.line_level = 1'b1;
					next_drive.clk_level = 1'b0;
				end
				RESET1_NEG:
				begin
					next_state.code = RESET1_POS;
					next_drive.clk_level = 1'b1;
				end
				RESET1_POS:
				begin
					next_state.code = RESET2_NEG;
					next_drive.clk_level = 1'b0;
				end
				RESET2_NEG:
				begin
					next_state.code = RESET2_POS;
					next_drive.clk_level = 1'b1;
				end
				RESET2_POS:
				begin
					next_state.code = RESET3_NEG;
					next_drive.clk_level = 1'b0;
				end
				RESET3_NEG:
				begin
					next_state.code = RESET3_POS;
					next_drive.clk_level = 1'b1;
				end
				RESET3_POS:
				begin
					next_state.code = BACK_TO_IDLE_NEG;
					next_drive.clk_level = 1'b0;
				end
				// Extra clock so every member returns to idle
				BACK_TO_IDLE_NEG:
				begin
					next_state.code = BACK_TO_IDLE_POS;
					next_drive.clk_level = 1'b1;
				end
				BACK_TO_IDLE_POS:
				begin
					next_state.code = BUS_IDLE;
				end
				default:
				begin
					next_state.code = BUS_IDLE;
				end
			endcase
		end

		// Take the line and start the reset pattern
		if (fault)
		begin
			next_state.code = RESET_S0_D_NEG;
			next_drive.clk_level = 1'b0;
			next_drive.hold = 1'b1;
			next_drive.line_level = RST_SEQ[2];
			next_drive.interject = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/bus_output_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_output_stage (
	input  logic             CLK,
	input  logic             RESET,
	input  ulpb_pkg::drive_t drive,
	input  logic             din_s,
	output logic             dout,
	output logic             clk_out,
	output logic [7:0]       reset_count
);

	// Both bus outputs leave from flops
	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			dout <= 1'b1;
			clk_out <= 1'b1;
		end
		else
		begin
			dout <= drive.hold ? drive.line_level : din_s;
			clk_out <= drive.clk_level;
		end
	end

	// Saturates at 255
	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			reset_count <= 8'd0;
		end
		else if (drive.interject && reset_count != 8'hff)
		begin
			reset_count <= reset_count + 8'd1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/ulpb_mediator_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module ulpb_mediator_top (
	input  logic       CLK,
	input  logic       RESET,
	input  logic       din,
	output logic       dout,
	output logic       clk_out,
	output logic [7:0] reset_count,
	output logic [5:0] bus_state
);

	import ulpb_pkg::*;

	sample_t sample;
	drive_t  drive;
	logic    sample_strobe;

	bus_sampler sampler0 (
		.CLK           (CLK),
		.RESET         (RESET),
		.din           (din),
		.sample_strobe (sample_strobe),
		.sample        (sample)
	);

	// State word doubles as the test point
	bus_mediator mediator0 (
		.CLK           (CLK),
		.RESET         (RESET),
		.sample        (sample),
		.sample_strobe (sample_strobe),
		.drive         (drive),
		.state         (bus_state)
	);

	bus_output_stage output0 (
		.CLK         (CLK),
		.RESET       (RESET),
		.drive       (drive),
		.din_s       (sample.din_s),
		.dout        (dout),
		.clk_out     (clk_out),
		.reset_count (reset_count)
	);

endmodule

`default_nettype wire

// ==== dv/ulpb_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module ulpb_assertions (
	input logic                 CLK,
	input logic                 RESET,
	input ulpb_pkg::med_state_u state,
	input ulpb_pkg::drive_t     drive
);

	import ulpb_pkg::*;

	// Mediator owns the line for the whole reset pattern
	hold_in_slow: assert property (@(posedge CLK) disable iff (!RESET)
		state.f.slow |-> drive.hold)
		else $error("line released in a quarter rate state");

	// Running bus clock toggles each cycle unless a fault takes over
	fast_clock_toggle: assert property (@(posedge CLK) disable iff (!RESET)
		(!state.f.slow && state.code != BUS_IDLE && state.code != WAIT_FOR_START)
		|=> (state.f.slow || drive.clk_level != $past(drive.clk_level)))
		else $error("bus clock stalled in a fast state");

	interject_pulse: assert property (@(posedge CLK) disable iff (!RESET)
		drive.interject |=> !drive.interject)
		else $error("interject held longer than one cycle");

endmodule

`default_nettype wire

// ==== dv/ulpb_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module ulpb_checker (
	input  logic       CLK,
	input  int         cyc,
	input  logic       dout,
	input  logic       clk_out,
	input  logic [7:0] reset_count,
	input  logic [5:0] bus_state,
	input  logic       exp_dout,
	input  logic       exp_clk,
	input  logic [7:0] exp_count,
	input  logic       exp_idle,
	output int         error_count,
	output int         check_count
);

	import ulpb_pkg::*;

	int errors = 0;
	int checks = 0;

	assign error_count = errors;
	assign check_count = checks;

	// Outputs are settled half a period after the edge
	always @(negedge CLK)
	begin
		checks = checks + 1;
		if (dout !== exp_dout)
		begin
			errors = errors + 1;
			$display("FAIL dout: got %h, expected %h, cycle %0d", dout, exp_dout, cyc);
		end
		if (clk_out !== exp_clk)
		begin
			errors = errors + 1;
			$display("FAIL clk_out: got %h, expected %h, cycle %0d", clk_out, exp_clk, cyc);
		end
		if (reset_count !== exp_count)
		begin
			errors = errors + 1;
			$display("FAIL reset_count: got %h, expected %h, cycle %0d",
				reset_count, exp_count, cyc);
		end
		if ((bus_state === BUS_IDLE) !== exp_idle)
		begin
			errors = errors + 1;
			if (exp_idle)
				$display("FAIL bus_state: got %h, expected %h, cycle %0d",
					bus_state, BUS_IDLE, cyc);
			else
				$display("FAIL bus_state: got %h, expected a state other than %h, cycle %0d",
					bus_state, BUS_IDLE, cyc);
		end
	end

endmodule

`default_nettype wire

// ==== dv/tb_ulpb.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_ulpb;

	import ulpb_pkg::*;

	localparam int PLAN_MAX = 512;
	localparam int NUM_SCEN = 3;
	// Pattern entry through the return to idle, 22 states of 2 cycles
	localparam int INTERJECT_CYCLES = 44;

	logic        CLK;
	logic        RESET;
	logic        din;
	logic        dout;
	logic        clk_out;
	logic [7:0]  reset_count;
	logic [5:0]  bus_state;
	logic        din_plan [0:PLAN_MAX-1];
	int          start_edge [0:NUM_SCEN-1];
	int          fault_edge [0:NUM_SCEN-1];
	int          cyc = 0;
	int          plan_len = 0;
	int          seed;
	logic [10:0] exp_vec;
	int          error_count;
	int          check_count;

	ulpb_mediator_top dut0 (
		.CLK         (CLK),
		.RESET       (RESET),
		.din         (din),
		.dout        (dout),
		.clk_out     (clk_out),
		.reset_count (reset_count),
		.bus_state   (bus_state)
	);

	ulpb_checker chk0 (
		.CLK         (CLK),
		.cyc         (cyc),
		.dout        (dout),
		.clk_out     (clk_out),
		.reset_count (reset_count),
		.bus_state   (bus_state),
		.exp_dout    (exp_vec[9]),
		.exp_clk     (exp_vec[8]),
		.exp_count   (exp_vec[7:0]),
		.exp_idle    (exp_vec[10]),
		.error_count (error_count),
		.check_count (check_count)
	);

	bind bus_mediator ulpb_assertions asrt0 (
		.CLK   (CLK),
		.RESET (RESET),
		.state (state),
		.drive (drive)
	);

	always #5 CLK = ~CLK;

	task automatic fill(input int from, input int to, input logic v);
		for (int i = from; i <= to && i < PLAN_MAX; i++)
			din_plan[i] = v;
	endtask

	// One random level per 8-cycle frame keeps the data in phase
	task automatic random_frames(input int k, input int frames);
		logic b;
		for (int n = 0; n < frames; n++)
		begin
			b = 1'($random(seed));
			fill(k + 16 + 8 * n, k + 23 + 8 * n, b);
		end
	endtask

	// Ring answers with the middle pattern bit, then the last one
	task automatic ring_reset_answer(input int f);
		fill(f + 6, f + 13, 1'b1);
		fill(f + 14, f + 21, 1'b0);
		fill(f + 22, PLAN_MAX - 1, 1'b1);
	endtask

	task automatic plan_message(input int s, input int k, input logic good_ack);
		start_edge[s] = k;
		fill(k, k + 15, 1'b0);
		random_frames(k, 2);
		// End of message marker: high then low at the second latch
		fill(k + 32, k + 38, 1'b1);
		fill(k + 39, k + 39, 1'b0);
		// First acknowledge bit in the next frame, the second one after it
		fill(k + 40, k + 43, good_ack ? ACK_SEQ[1] : ~ACK_SEQ[1]);
		fill(k + 44, PLAN_MAX - 1, ACK_SEQ[0]);
		fault_edge[s] = good_ack ? k + 51 : k + 47;
		ring_reset_answer(fault_edge[s]);
	endtask

	// Expected {idle, dout, clk_out, reset_count} for a cycle
	function automatic logic [10:0] ref_outputs(input int c);
		logic       idle;
		logic       d;
		logic       ck;
		logic [7:0] cnt;
		int         k;
		int         f;
		int         idx;
		idle = 1'b1;
		d = 1'b1;
		ck = 1'b1;
		cnt = 8'd0;
		for (int s = 0; s < NUM_SCEN; s++)
		begin
			k = start_edge[s];
			f = fault_edge[s];
			if (c >= f + 1)
				cnt = cnt + 8'd1;
			if (c >= k + 3 && c < f + INTERJECT_CYCLES)
				idle = 1'b0;
			if (c >= k + 17 && c <= f)
			begin
				ck = ((c - k - 17) % 2) != 0;
				if (c >= k + 20)
					d = din_plan[c - 3];
			end
			else if (c > f && c <= f + INTERJECT_CYCLES)
			begin
				idx = (c - 1 - f) / 2;
				ck = (idx % 2) != 0;
				d = (idx >= 4 && idx < 8) || idx >= 14;
			end
		end
		return {idle, d, ck, cnt};
	endfunction

	always @(posedge CLK)
	begin
		cyc <= cyc + 1;
		if (cyc + 1 < PLAN_MAX)
			din <= din_plan[cyc + 1];
	end

	always @(cyc)
		exp_vec = ref_outputs(cyc);

	always @(posedge CLK)
	begin
		if (plan_len > 0 && cyc > plan_len + 200)
		begin
			$display("Timeout: mediator did not return to idle by cycle %0d", cyc);
			$display("Finished with errors");
			$finish;
		end
	end

	initial
	begin
		int k;
		logic b;
		CLK = 1'b0;
		RESET = 1'b0;
		din = 1'b1;
		seed = 32'he7b4;
		fill(0, PLAN_MAX - 1, 1'b1);

		// Phase fault inside the fourth drive phase
		k = 40;
		start_edge[0] = k;
		fill(k, k + 15, 1'b0);
		random_frames(k, 3);
		b = 1'($random(seed));
		fill(k + 40, k + 40, b);
		fill(k + 41, PLAN_MAX - 1, ~b);
		fault_edge[0] = k + 45;
		ring_reset_answer(fault_edge[0]);

		plan_message(1, fault_edge[0] + INTERJECT_CYCLES + 16, 1'b1);
		plan_message(2, fault_edge[1] + INTERJECT_CYCLES + 16, 1'b0);
		plan_len = fault_edge[2] + INTERJECT_CYCLES + 20;
		exp_vec = ref_outputs(0);

		repeat (10) @(posedge CLK);
		RESET <= 1'b1;
		wait (cyc >= plan_len && bus_state == BUS_IDLE);
		@(negedge CLK);
		#1;
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/ulpb_pkg.sv
logic/bus_sampler.sv
logic/bus_mediator.sv
logic/bus_output_stage.sv
logic/ulpb_mediator_top.sv
dv/ulpb_assertions.sv
dv/ulpb_checker.sv
dv/tb_ulpb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f \
	--top-module tb_ulpb \
	-o sim_ulpb

./obj_dir/sim_ulpb | tee sim.log

if grep -q "Finished with errors" sim.log; then
	echo "Simulation failed"
	exit 1
fi

echo "Simulation passed"
